//--- design/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
    input  cpuPkg::byte_t romData,
    input  cpuPkg::byte_t regA,
    input  cpuPkg::byte_t regB,
    output cpuPkg::byte_t aluResult
);
    import cpuPkg::*;

    // Operation comes from the high nibble of the current opcode
    aluOp_t aluOp;
    // Low byte of A times B
    byte_t product;

    assign aluOp = romData[7:4];
    assign product = regA * regB;

    always_comb begin
        case (aluOp)
            ALU_ADD:   aluResult = regA + regB;
            ALU_SUB:   aluResult = regA - regB;
            ALU_MUL:   aluResult = product;
            // Shifts act on A only
            ALU_SHL:   aluResult = regA << 1;
            ALU_SHR:   aluResult = regA >> 1;
            ALU_INC_A: aluResult = regA + 8'd1;
            ALU_INC_B: aluResult = regB + 8'd1;
            ALU_DEC_A: aluResult = regA - 8'd1;
            ALU_DEC_B: aluResult = regB - 8'd1;
            // Compares give 1 or 0, the branch tests for 1
            ALU_EQ:    aluResult = (regA == regB) ? 8'h01 : 8'h00;
            ALU_GT:    aluResult = (regA > regB) ? 8'h01 : 8'h00;
            ALU_LT:    aluResult = (regA < regB) ? 8'h01 : 8'h00;
            default:   aluResult = 8'h00;
        endcase
    end

endmodule

//--- design/busPort.sv
`timescale 1ns/1ns

module busPort (
    input  logic              CLK,
    input  logic              RESET,
    input  cpuPkg::busCtrl_t  busCtl,
    input  cpuPkg::byte_t     romData,
    input  cpuPkg::byte_t     regA,
    input  cpuPkg::byte_t     regB,
    output cpuPkg::byte_t     busAddr,
    output cpuPkg::byte_t     busDataOut,
    output logic              busWe
);
    import cpuPkg::*;

    // Address and strobe, idle address between accesses
    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= BUS_IDLE_ADDR;
            busWe <= 1'b0;
        end else begin
            busAddr <= busCtl.drive ? romData : BUS_IDLE_ADDR;
            busWe <= busCtl.write;
        end
    end

    // Write data lines up with busWe, held otherwise
    always_ff @(posedge CLK) begin
        if (busCtl.write) begin
            busDataOut <= busCtl.fromB ? regB : regA;
        end
    end

endmodule

//--- design/cpuPkg.sv
package cpuPkg;

    ////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////

    // Data, address and instruction byte
    typedef logic [7:0] byte_t;
    // One bit per interrupt line
    typedef logic [1:0] irqVec_t;
    // Instruction class, low nibble of the opcode byte
    typedef logic [3:0] opLow_t;
    // ALU select, high nibble of the opcode byte
    typedef logic [3:0] aluOp_t;

    // Instruction classes
    localparam opLow_t OP_READ_A    = 4'd0;
    localparam opLow_t OP_READ_B    = 4'd1;
    localparam opLow_t OP_WRITE_A   = 4'd2;
    localparam opLow_t OP_WRITE_B   = 4'd3;
    localparam opLow_t OP_MATH_A    = 4'd4;
    localparam opLow_t OP_MATH_B    = 4'd5;
    localparam opLow_t OP_BRANCH_EQ = 4'd6;
    localparam opLow_t OP_GOTO      = 4'd7;
    localparam opLow_t OP_IDLE      = 4'd8;

    // ALU operations
    localparam aluOp_t ALU_ADD   = 4'd0;
    localparam aluOp_t ALU_SUB   = 4'd1;
    localparam aluOp_t ALU_MUL   = 4'd2;
    localparam aluOp_t ALU_SHL   = 4'd3;
    localparam aluOp_t ALU_SHR   = 4'd4;
    localparam aluOp_t ALU_INC_A = 4'd5;
    localparam aluOp_t ALU_INC_B = 4'd6;
    localparam aluOp_t ALU_DEC_A = 4'd7;
    localparam aluOp_t ALU_DEC_B = 4'd8;
    localparam aluOp_t ALU_EQ    = 4'd9;
    localparam aluOp_t ALU_GT    = 4'd10;
    localparam aluOp_t ALU_LT    = 4'd11;

    // Fixed addresses
    localparam byte_t VEC_IRQ0      = 8'hFF;
    localparam byte_t VEC_IRQ1      = 8'hFE;
    localparam byte_t BUS_IDLE_ADDR = 8'hFF;
    localparam byte_t PC_RESET      = 8'h00;

    ////////////////////////////////////////
    // Sequencer states and control words
    ////////////////////////////////////////

    typedef enum logic [4:0] {
        ST_CHOOSE, ST_IDLE, ST_THREAD_0, ST_THREAD_1, ST_THREAD_2,
        ST_READ_A, ST_READ_B, ST_READ_0, ST_READ_1, ST_READ_2,
        ST_WRITE_A, ST_WRITE_B, ST_WRITE_0,
        ST_MATH_A, ST_MATH_B, ST_MATH_0,
        ST_BRANCH_EQ, ST_BRANCH_0, ST_BRANCH_1, ST_BRANCH_2,
        ST_GOTO, ST_GOTO_0, ST_GOTO_1
    } seqState_t;

    // Program counter update
    typedef enum logic [2:0] {
        PC_HOLD, PC_STEP1, PC_STEP2, PC_LOAD_ROM, PC_LOAD_VEC0, PC_LOAD_VEC1
    } pcOp_t;

    typedef struct packed {
        pcOp_t      pcOp;
        logic [1:0] fetchOffset;
    } pcCtrl_t;

    // srcAlu set takes the ALU result, clear takes busDataIn
    typedef struct packed {
        logic loadA;
        logic loadB;
        logic srcAlu;
    } regCtrl_t;

    typedef struct packed {
        logic drive;
        logic write;
        logic fromB;
    } busCtrl_t;

endpackage

//--- design/miniCpu.sv
`timescale 1ns/1ns

module miniCpu (
    input  logic             CLK,
    input  logic             RESET,
    output cpuPkg::byte_t    romAddr,
    input  cpuPkg::byte_t    romData,
    output cpuPkg::byte_t    busAddr,
    input  cpuPkg::byte_t    busDataIn,
    output cpuPkg::byte_t    busDataOut,
    output logic             busWe,
    input  cpuPkg::irqVec_t  irqRaise,
    output cpuPkg::irqVec_t  irqAck
);
    import cpuPkg::*;

    // Control from the sequencer
    pcCtrl_t pcCtl;
    regCtrl_t regCtl;
    busCtrl_t busCtl;
    // Datapath
    byte_t regA;
    byte_t regB;
    byte_t aluResult;

    opSequencer opSeq (
        .CLK(CLK), .RESET(RESET),
        .romData(romData), .aluResult(aluResult),
        .irqRaise(irqRaise), .irqAck(irqAck),
        .pcCtl(pcCtl), .regCtl(regCtl), .busCtl(busCtl)
    );

    progCounter progCnt (
        .CLK(CLK), .RESET(RESET),
        .pcCtl(pcCtl), .romData(romData), .romAddr(romAddr)
    );

    regBank regs (
        .CLK(CLK), .RESET(RESET),
        .regCtl(regCtl), .busDataIn(busDataIn), .aluResult(aluResult),
        .regA(regA), .regB(regB)
    );

    // ALU select rides on the opcode byte
    aluUnit alu (
        .romData(romData), .regA(regA), .regB(regB), .aluResult(aluResult)
    );

    busPort busIf (
        .CLK(CLK), .RESET(RESET),
        .busCtl(busCtl), .romData(romData), .regA(regA), .regB(regB),
        .busAddr(busAddr), .busDataOut(busDataOut), .busWe(busWe)
    );

endmodule

//--- design/opSequencer.sv
`timescale 1ns/1ns

module opSequencer (
    input  logic              CLK,
    input  logic              RESET,
    input  cpuPkg::byte_t     romData,
    input  cpuPkg::byte_t     aluResult,
    input  cpuPkg::irqVec_t   irqRaise,
    output cpuPkg::irqVec_t   irqAck,
    output cpuPkg::pcCtrl_t   pcCtl,
    output cpuPkg::regCtrl_t  regCtl,
    output cpuPkg::busCtrl_t  busCtl
);
    import cpuPkg::*;

    seqState_t state;
    seqState_t stateNext;
    // Destination of a read, set for B
    logic readToB;
    logic readToBNext;
    irqVec_t ackNext;
    opLow_t opCode;

    assign opCode = romData[3:0];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= ST_CHOOSE;
            readToB <= 1'b0;
            irqAck <= '0;
        end else begin
            state <= stateNext;
            readToB <= readToBNext;
            irqAck <= ackNext;
        end
    end

    // Control words are next-cycle values, the data modules register them
    always_comb begin
        stateNext = state;
        readToBNext = readToB;
        ackNext = '0;
        pcCtl = '{pcOp: PC_HOLD, fetchOffset: 2'd0};
        regCtl = '0;
        busCtl = '0;
        case (state)
            ////////////////////////////////////////
            // Thread start
            ////////////////////////////////////////
            // Line 0 wins when both are raised
            ST_IDLE: begin
                if (irqRaise[0]) begin
                    stateNext = ST_THREAD_0;
                    pcCtl.pcOp = PC_LOAD_VEC0;
                    ackNext = 2'b01;
                end else if (irqRaise[1]) begin
                    stateNext = ST_THREAD_0;
                    pcCtl.pcOp = PC_LOAD_VEC1;
                    ackNext = 2'b10;
                end
            end
            ST_THREAD_0: stateNext = ST_THREAD_1;
            // ROM now shows the vector byte
            ST_THREAD_1: begin
                stateNext = ST_THREAD_2;
                pcCtl.pcOp = PC_LOAD_ROM;
            end
            ST_THREAD_2: stateNext = ST_CHOOSE;

            ////////////////////////////////////////
            // Decode
            ////////////////////////////////////////
            // Offset 1 only where the second byte is needed, math and branch
            // keep the opcode on the ROM for the ALU select
            ST_CHOOSE: begin
                case (opCode)
                    OP_READ_A: begin
                        stateNext = ST_READ_A;
                        pcCtl.fetchOffset = 2'd1;
                    end
                    OP_READ_B: begin
                        stateNext = ST_READ_B;
                        pcCtl.fetchOffset = 2'd1;
                    end
                    OP_WRITE_A: begin
                        stateNext = ST_WRITE_A;
                        pcCtl.fetchOffset = 2'd1;
                    end
                    OP_WRITE_B: begin
                        stateNext = ST_WRITE_B;
                        pcCtl.fetchOffset = 2'd1;
                    end
                    OP_MATH_A:    stateNext = ST_MATH_A;
                    OP_MATH_B:    stateNext = ST_MATH_B;
                    OP_BRANCH_EQ: stateNext = ST_BRANCH_EQ;
                    OP_GOTO: begin
                        stateNext = ST_GOTO;
                        pcCtl.fetchOffset = 2'd1;
                    end
                    OP_IDLE:      stateNext = ST_IDLE;
                    // Unknown classes park as well
                    default:      stateNext = ST_IDLE;
                endcase
            end

            ////////////////////////////////////////
            // Memory read
            ////////////////////////////////////////
            ST_READ_A, ST_READ_B: begin
                stateNext = ST_READ_0;
                readToBNext = (state == ST_READ_B);
                pcCtl.fetchOffset = 2'd1;
            end
            // Operand address on the ROM, latch it onto the bus
            ST_READ_0: begin
                stateNext = ST_READ_1;
                pcCtl.fetchOffset = 2'd1;
                busCtl.drive = 1'b1;
            end
            // Hold the address one more cycle and move past the instruction
            ST_READ_1: begin
                stateNext = ST_READ_2;
                pcCtl.pcOp = PC_STEP2;
                busCtl.drive = 1'b1;
            end
            ST_READ_2: begin
                stateNext = ST_CHOOSE;
                regCtl.loadA = !readToB;
                regCtl.loadB = readToB;
            end

            ////////////////////////////////////////
            // Memory write
            ////////////////////////////////////////
            ST_WRITE_A, ST_WRITE_B: begin
                stateNext = ST_WRITE_0;
                pcCtl.pcOp = PC_STEP2;
                busCtl.drive = 1'b1;
                busCtl.write = 1'b1;
                busCtl.fromB = (state == ST_WRITE_B);
            end
            // busWe is high here
            ST_WRITE_0: stateNext = ST_CHOOSE;

            // ALU result saved, step one byte
            ST_MATH_A, ST_MATH_B: begin
                stateNext = ST_MATH_0;
                pcCtl.pcOp = PC_STEP1;
                regCtl.loadA = (state == ST_MATH_A);
                regCtl.loadB = (state == ST_MATH_B);
                regCtl.srcAlu = 1'b1;
            end
            ST_MATH_0: stateNext = ST_CHOOSE;

            ////////////////////////////////////////
            // Branch and goto
            ////////////////////////////////////////
            // Taken points at the target byte, not taken skips it
            ST_BRANCH_EQ: begin
                if (aluResult == 8'h01) begin
                    stateNext = ST_BRANCH_1;
                    pcCtl.pcOp = PC_STEP1;
                end else begin
                    stateNext = ST_BRANCH_0;
                    pcCtl.pcOp = PC_STEP2;
                end
            end
            ST_BRANCH_1: begin
                stateNext = ST_BRANCH_2;
                pcCtl.pcOp = PC_LOAD_ROM;
            end
            ST_BRANCH_0: stateNext = ST_BRANCH_2;
            ST_BRANCH_2: stateNext = ST_CHOOSE;
            ST_GOTO: begin
                stateNext = ST_GOTO_0;
                pcCtl.fetchOffset = 2'd1;
            end
            ST_GOTO_0: begin
                stateNext = ST_GOTO_1;
                pcCtl.pcOp = PC_LOAD_ROM;
            end
            ST_GOTO_1: stateNext = ST_CHOOSE;
            default: stateNext = ST_CHOOSE;
        endcase
    end

endmodule

//--- design/progCounter.sv
`timescale 1ns/1ns

module progCounter (
    input  logic             CLK,
    input  logic             RESET,
    input  cpuPkg::pcCtrl_t  pcCtl,
    input  cpuPkg::byte_t    romData,
    output cpuPkg::byte_t    romAddr
);
    import cpuPkg::*;

    // Address of the current opcode
    byte_t pcValue;
    // Offset into the current instruction, 1 points at its operand byte
    logic [1:0] fetchOff;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pcValue <= PC_RESET;
            fetchOff <= 2'd0;
        end else begin
            fetchOff <= pcCtl.fetchOffset;
            case (pcCtl.pcOp)
                PC_STEP1:     pcValue <= pcValue + 8'd1;
                PC_STEP2:     pcValue <= pcValue + 8'd2;
                // Jump and thread targets arrive on the ROM data
                PC_LOAD_ROM:  pcValue <= romData;
                PC_LOAD_VEC0: pcValue <= VEC_IRQ0;
                PC_LOAD_VEC1: pcValue <= VEC_IRQ1;
                default:      pcValue <= pcValue;
            endcase
        end
    end

    // ROM reads asynchronously, so this address is answered in the same cycle
    assign romAddr = pcValue + byte_t'(fetchOff);

endmodule

//--- design/regBank.sv
`timescale 1ns/1ns

module regBank (
    input  logic              CLK,
    input  logic              RESET,
    input  cpuPkg::regCtrl_t  regCtl,
    input  cpuPkg::byte_t     busDataIn,
    input  cpuPkg::byte_t     aluResult,
    output cpuPkg::byte_t     regA,
    output cpuPkg::byte_t     regB
);
    import cpuPkg::*;

    // Shared load value for both registers
    byte_t loadValue;

    assign loadValue = regCtl.srcAlu ? aluResult : busDataIn;

    // Working registers
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= 8'h00;
            regB <= 8'h00;
        end else begin
            if (regCtl.loadA) begin
                regA <= loadValue;
            end
            if (regCtl.loadB) begin
                regB <= loadValue;
            end
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cpuTb -f src.f -o simCpu > build.log 2>&1 \
    && ./obj_dir/simCpu > sim.log 2>&1
grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;
    import cpuPkg::*;

    logic CLK;
    logic RESET;
    byte_t romAddr;
    byte_t romData;
    byte_t busAddr;
    byte_t busDataIn;
    byte_t busDataOut;
    logic busWe;
    irqVec_t irqRaise;
    irqVec_t irqAck;

    // Memory models that answer in the same cycle
    byte_t rom [256];
    byte_t ram [256];

    // Expected writes in program order
    byte_t expAddr[$];
    byte_t expData[$];
    int wrIdx;
    logic headValid;
    byte_t headAddr;
    byte_t headData;

    // Assembler and reference register state
    byte_t asmPtr;
    logic modelOn;
    byte_t modelA;
    byte_t modelB;
    int latSum;

    logic [31:0] lfsrState;
    int cycleCount;
    int cycleLimit;
    // Set while the CPU must sit parked with no bus writes
    logic quiet;
    irqVec_t expAck;

    assign romData = rom[romAddr];
    assign busDataIn = ram[busAddr];

    miniCpu dut_i (
        .CLK(CLK), .RESET(RESET),
        .romAddr(romAddr), .romData(romData),
        .busAddr(busAddr), .busDataIn(busDataIn), .busDataOut(busDataOut),
        .busWe(busWe), .irqRaise(irqRaise), .irqAck(irqAck)
    );

    bind miniCpu miniCpu_props propsInst (
        .CLK(CLK), .RESET(RESET), .busAddr(busAddr), .busWe(busWe),
        .irqRaise(irqRaise), .irqAck(irqAck), .seqState(opSeq.state)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // Fibonacci taps 32 22 2 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic byte_t lfsrByte();
        byte_t v;
        v = 8'h00;
        for (int i = 0; i < 8; i++) begin
            v = {v[6:0], lfsrBit()};
        end
        return v;
    endfunction

    // Reference ALU from the instruction table
    function automatic byte_t aluModel(input aluOp_t op, input byte_t a, input byte_t b);
        logic [15:0] prod;
        prod = {8'h00, a} * {8'h00, b};
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return prod[7:0];
            4'd3:    return {a[6:0], 1'b0};
            4'd4:    return {1'b0, a[7:1]};
            4'd5:    return a + 8'd1;
            4'd6:    return b + 8'd1;
            4'd7:    return a - 8'd1;
            4'd8:    return b - 8'd1;
            4'd9:    return (a == b) ? 8'h01 : 8'h00;
            4'd10:   return (a > b) ? 8'h01 : 8'h00;
            4'd11:   return (a < b) ? 8'h01 : 8'h00;
            default: return 8'h00;
        endcase
    endfunction

    task automatic loadHead();
        headValid = (wrIdx < expAddr.size());
        if (headValid) begin
            headAddr = expAddr[wrIdx];
            headData = expData[wrIdx];
        end
    endtask

    task automatic emitByte(input byte_t b);
        rom[asmPtr] = b;
        asmPtr = asmPtr + 8'd1;
    endtask

    // Model is only stepped on the path the CPU really runs
    task automatic emitRead(input logic toB, input byte_t addr);
        emitByte(toB ? 8'h01 : 8'h00);
        emitByte(addr);
        if (modelOn) begin
            if (toB) modelB = ram[addr];
            else modelA = ram[addr];
            latSum += 5;
        end
    endtask

    task automatic emitMath(input logic toB, input aluOp_t op);
        byte_t r;
        emitByte({op, toB ? 4'h5 : 4'h4});
        if (modelOn) begin
            r = aluModel(op, modelA, modelB);
            if (toB) modelB = r;
            else modelA = r;
            latSum += 3;
        end
    endtask

    task automatic emitWrite(input logic fromB, input byte_t addr);
        emitByte(fromB ? 8'h03 : 8'h02);
        emitByte(addr);
        if (modelOn) begin
            expAddr.push_back(addr);
            expData.push_back(fromB ? modelB : modelA);
            latSum += 3;
        end
    endtask

    // Target byte is patched once the label is known
    task automatic emitJump(input byte_t opc, output byte_t pos);
        emitByte(opc);
        pos = asmPtr;
        emitByte(8'h00);
        if (modelOn) latSum += 4;
    endtask

    task automatic emitIdle();
        emitByte(8'h08);
        if (modelOn) latSum += 1;
    endtask

    // Equality branch picking marker 0xA5 when taken, 0x5A when not
    task automatic branchSection(input byte_t addrA, input byte_t addrB, input byte_t dest);
        byte_t brPos;
        byte_t gotoPos;
        logic taken;
        emitRead(1'b0, addrA);
        emitRead(1'b1, addrB);
        taken = (aluModel(4'd9, modelA, modelB) == 8'h01);
        emitJump({4'd9, 4'h6}, brPos);
        modelOn = !taken;
        emitRead(1'b0, 8'h81);
        emitWrite(1'b0, dest);
        emitJump(8'h07, gotoPos);
        rom[brPos] = asmPtr;
        modelOn = taken;
        emitRead(1'b0, 8'h80);
        emitWrite(1'b0, dest);
        modelOn = 1'b1;
        rom[gotoPos] = asmPtr;
    endtask

    task automatic assemble();
        byte_t skipPos;
        asmPtr = 8'h00;
        modelOn = 1'b1;
        modelA = 8'h00;
        modelB = 8'h00;
        latSum = 0;
        // Every ALU code plus one undefined code
        for (int i = 0; i < 13; i++) begin
            emitRead(1'b0, 8'h10 + 8'(i));
            emitRead(1'b1, 8'h20 + 8'(i));
            emitMath(i[0], 4'(i));
            emitWrite(i[0], 8'h40 + 8'(i));
        end
        branchSection(8'h82, 8'h82, 8'h50);
        branchSection(8'h82, 8'h83, 8'h51);
        // Goto over a write that must never show up
        emitJump(8'h07, skipPos);
        modelOn = 1'b0;
        emitWrite(1'b0, 8'h60);
        modelOn = 1'b1;
        rom[skipPos] = asmPtr;
        emitWrite(1'b1, 8'h61);
        emitIdle();
    endtask

    task automatic assembleThreads();
        // Line 1 thread
        asmPtr = 8'hB0;
        rom[VEC_IRQ1] = asmPtr;
        latSum += 4;
        emitRead(1'b0, 8'h18);
        emitRead(1'b1, 8'h28);
        emitMath(1'b0, 4'd1);
        emitWrite(1'b0, 8'h70);
        emitIdle();
        // Line 0 thread
        asmPtr = 8'hD0;
        rom[VEC_IRQ0] = asmPtr;
        latSum += 4;
        emitRead(1'b0, 8'h19);
        emitRead(1'b1, 8'h29);
        emitMath(1'b1, 4'd0);
        emitWrite(1'b1, 8'h71);
        emitIdle();
    endtask

    task automatic holdQuiet(input int n);
        quiet = 1'b1;
        repeat (n) @(posedge CLK);
        quiet = 1'b0;
    endtask

    task automatic raiseIrq(input irqVec_t lines, input irqVec_t ack);
        expAck = ack;
        @(posedge CLK);
        #2 irqRaise = lines;
        do begin
            @(posedge CLK);
            #2;
        end while (irqAck == 2'b00);
        irqRaise = 2'b00;
    endtask

    ////////////////////////////////////////
    // Memory write, scoreboard and timeout
    ////////////////////////////////////////

    always @(posedge CLK) begin
        if (busWe) begin
            ram[busAddr] = busDataOut;
        end
    end

    always @(posedge CLK) begin
        if (!RESET && busWe) begin
            wrIdx = wrIdx + 1;
            loadHead();
        end
    end

    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            failRun("timeout, expected writes did not all arrive");
        end
    end

    // Checked mid-cycle where the outputs are settled
    writeExpected: assert property (@(negedge CLK) disable iff (RESET) busWe |-> headValid)
        else failRun($sformatf("unexpected bus write at address %h", busAddr));

    writeValue: assert property (@(negedge CLK) disable iff (RESET)
        (busWe && headValid) |-> (busAddr == headAddr && busDataOut == headData))
        else failRun($sformatf("mismatch busAddr exp %h got %h busDataOut exp %h got %h",
                               headAddr, busAddr, headData, busDataOut));

    parkedNoWrite: assert property (@(negedge CLK) disable iff (RESET) quiet |-> !busWe)
        else failRun("bus write while the CPU should be parked");

    ackValue: assert property (@(negedge CLK) disable iff (RESET)
        (irqAck != 2'b00) |-> (irqAck == expAck))
        else failRun($sformatf("mismatch irqAck exp %h got %h", expAck, irqAck));

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int mainCount;
        int line1Count;
        RESET = 1'b1;
        irqRaise = 2'b00;
        quiet = 1'b0;
        expAck = 2'b00;
        wrIdx = 0;
        cycleCount = 0;
        lfsrState = 32'h609f9bf5;
        // Unused ROM decodes as idle with an address-dependent high nibble
        for (int i = 0; i < 256; i++) begin
            ram[i] = lfsrByte();
            rom[i] = {i[7:4] ^ i[3:0], OP_IDLE};
        end
        // Branch markers and compare operands
        ram[8'h80] = 8'hA5;
        ram[8'h81] = 8'h5A;
        ram[8'h82] = 8'h33;
        ram[8'h83] = 8'h34;
        assemble();
        mainCount = expAddr.size();
        assembleThreads();
        line1Count = mainCount + 1;
        cycleLimit = 2 * latSum + 200;
        loadHead();

        repeat (10) @(posedge CLK);
        #2 RESET = 1'b0;

        wait (wrIdx == mainCount);
        holdQuiet(20);
        raiseIrq(2'b10, 2'b10);
        wait (wrIdx == line1Count);
        holdQuiet(10);
        raiseIrq(2'b11, 2'b01);
        wait (wrIdx == expAddr.size());
        holdQuiet(10);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- sim/miniCpu_props.sv
`timescale 1ns/1ns

module miniCpu_props (
    input logic              CLK,
    input logic              RESET,
    input cpuPkg::byte_t     busAddr,
    input logic              busWe,
    input cpuPkg::irqVec_t   irqRaise,
    input cpuPkg::irqVec_t   irqAck,
    input cpuPkg::seqState_t seqState
);
    import cpuPkg::*;

    // Bus address is live only while a read holds it or a write strobes
    logic busActive;

    assign busActive = (seqState == ST_READ_1) || (seqState == ST_READ_2) ||
                       (seqState == ST_WRITE_0);

    ////////////////////////////////////////
    // Interrupt acknowledge
    ////////////////////////////////////////

    ackOneHot: assert property (@(posedge CLK) disable iff (RESET) $onehot0(irqAck))
        else $error("irqAck has more than one bit set");

    ackOneCycle: assert property (@(posedge CLK) disable iff (RESET)
        (irqAck != 2'b00) |=> (irqAck == 2'b00))
        else $error("irqAck held longer than one cycle");

    // Each ack bit needs its own line raised the cycle before
    ackFromLine0: assert property (@(posedge CLK) disable iff (RESET)
        irqAck[0] |-> $past(irqRaise[0]))
        else $error("irqAck line 0 without a raised line");

    ackFromLine1: assert property (@(posedge CLK) disable iff (RESET)
        irqAck[1] |-> $past(irqRaise[1]))
        else $error("irqAck line 1 without a raised line");

    ////////////////////////////////////////
    // Bus outputs
    ////////////////////////////////////////

    quietAfterReset: assert property (@(posedge CLK)
        $fell(RESET) |-> (!busWe && (irqAck == 2'b00)))
        else $error("busWe or irqAck set right after reset");

    idleAddress: assert property (@(posedge CLK) disable iff (RESET)
        !busActive |-> (busAddr == BUS_IDLE_ADDR))
        else $error("busAddr left the idle address with no access");

endmodule

//--- src.f
design/cpuPkg.sv
design/aluUnit.sv
design/progCounter.sv
design/opSequencer.sv
design/regBank.sv
design/busPort.sv
design/miniCpu.sv
sim/miniCpu_props.sv
sim/cpuTb.sv
